// File: rv_isa_pkg.sv
package rv_isa_pkg;

  typedef logic [31:0] inst_t;
  typedef logic [6:0] opcode_t;

  // major opcodes, inst[6:0]
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_BRANCH = 7'b1100011;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_SYSTEM = 7'b1110011;

  // fence.i, rd = rs1 = 0 and imm = 0
  localparam inst_t INST_FENCE_I = 32'h0000_100f;

  function automatic opcode_t opcode_of(inst_t inst);
    return inst[6:0];
  endfunction

  // anything that may leave the sequential path
  function automatic logic is_control(inst_t inst);
    opcode_t op;
    op = opcode_of(inst);
    return (op == OP_JAL) || (op == OP_JALR) ||
           (op == OP_BRANCH) || (op == OP_SYSTEM);
  endfunction

  function automatic logic is_load(inst_t inst);
    return opcode_of(inst) == OP_LOAD;
  endfunction

  function automatic logic is_store(inst_t inst);
    return opcode_of(inst) == OP_STORE;
  endfunction

endpackage

// File: fetch_pkg.sv
package fetch_pkg;

  typedef logic [31:0] addr_t;

  localparam addr_t PC_INIT = 32'h0000_1000;

  // l1i geometry
  localparam int L1I_SETS_LOG2   = 2;
  localparam int L1I_LINE_LOG2   = 1;
  localparam int L1I_BYTE_LOG2   = 2;
  localparam int L1I_SETS        = 1 << L1I_SETS_LOG2;
  localparam int L1I_LINE_WORDS  = 1 << L1I_LINE_LOG2;
  localparam int TAG_W           = 32 - L1I_SETS_LOG2 - L1I_LINE_LOG2 - L1I_BYTE_LOG2;
  localparam int L1I_LINE_ADDR_W = TAG_W + L1I_SETS_LOG2;

  // field boundaries inside addr_t
  localparam int OFF_LSB = L1I_BYTE_LOG2;
  localparam int IDX_LSB = OFF_LSB + L1I_LINE_LOG2;
  localparam int TAG_LSB = IDX_LSB + L1I_SETS_LOG2;

  typedef struct packed {
    addr_t             pc;
    rv_isa_pkg::inst_t inst;
  } fetch_out_t;

  typedef struct packed {
    logic  redirect;
    logic  retire;
    addr_t pc;
    addr_t npc;
  } commit_t;

  typedef struct packed {
    logic active;
    logic good;
    logic bad;
  } spec_status_t;

  typedef struct packed {
    logic  psel;
    logic  penable;
    addr_t paddr;
  } apb_req_t;

  typedef struct packed {
    logic        pready;
    logic [31:0] prdata;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic  valid;
    addr_t addr;
  } word_req_t;

  typedef struct packed {
    logic        valid;
    logic [31:0] data;
  } word_rsp_t;

endpackage

// File: fetch_ctrl.sv
module fetch_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  fetch_pkg::commit_t      commit_i,
  input  logic                    hit_i,
  input  rv_isa_pkg::inst_t       inst_i,
  input  logic                    cache_idle_i,
  input  logic                    fetch_ready_i,
  output fetch_pkg::addr_t        lookup_addr_o,
  output logic                    invalidate_o,
  output logic                    fetch_valid_o,
  output fetch_pkg::fetch_out_t   fetch_o,
  output fetch_pkg::spec_status_t spec_o
);

  fetch_pkg::addr_t pc_q;
  fetch_pkg::addr_t pc_plus4;
  logic             hazard_q;

  // single target entry
  fetch_pkg::addr_t btb_q;
  logic             btb_valid_q;

  // pending guess
  logic             spec_q;
  logic             cond_q;
  logic             good_q;
  logic             bad_q;
  fetch_pkg::addr_t guess_pc_q;
  fetch_pkg::addr_t guess_target_q;
  fetch_pkg::addr_t fall_through_q;
  fetch_pkg::addr_t restart_pc_q;

  logic             is_ctrl;
  logic             is_cond;
  logic             is_load;
  logic             is_store;
  logic             is_fence;
  logic             committing;
  fetch_pkg::addr_t commit_target;
  logic             resolve;
  logic             mismatch;
  logic             bad_now;
  logic             resume;
  logic             restart;
  logic             accept;
  logic             predict;

  assign pc_plus4 = pc_q + 32'd4;

  assign is_ctrl  = rv_isa_pkg::is_control(inst_i);
  assign is_cond  = rv_isa_pkg::opcode_of(inst_i) == rv_isa_pkg::OP_BRANCH;
  assign is_load  = rv_isa_pkg::is_load(inst_i);
  assign is_store = rv_isa_pkg::is_store(inst_i);
  assign is_fence = inst_i == rv_isa_pkg::INST_FENCE_I;

  // where the committing instruction really went
  assign committing    = commit_i.redirect || commit_i.retire;
  assign commit_target = commit_i.redirect ? commit_i.npc : commit_i.pc + 32'd4;

  assign resolve  = spec_q && committing && (commit_i.pc == guess_pc_q);
  assign mismatch = resolve && (commit_target != guess_target_q);
  assign bad_now  = bad_q || mismatch;

  // a stalled instruction sits at pc_q until its own commit
  assign resume  = hazard_q && committing && (commit_i.pc == pc_q);
  assign restart = bad_q && cache_idle_i && fetch_ready_i;

  // memory ops wait until the guess is settled
  assign fetch_valid_o = hit_i && !hazard_q && !bad_now &&
                         !(spec_q && (is_load || is_store));
  assign accept        = fetch_valid_o && fetch_ready_i;
  assign predict       = accept && is_ctrl && btb_valid_q && !spec_q;
  assign invalidate_o  = accept && is_fence;
  assign lookup_addr_o = pc_q;

  always_comb begin
    fetch_o.pc     = pc_q;
    fetch_o.inst   = inst_i;
    spec_o.active  = spec_q;
    spec_o.good    = good_q;
    spec_o.bad     = bad_now;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q        <= fetch_pkg::PC_INIT;
      hazard_q    <= 1'b0;
      btb_valid_q <= 1'b0;
      spec_q      <= 1'b0;
      cond_q      <= 1'b0;
      good_q      <= 1'b0;
      bad_q       <= 1'b0;
    end else begin
      good_q <= resolve && !mismatch;
      if (commit_i.redirect) begin
        btb_valid_q <= 1'b1;
      end
      if (resolve) begin
        spec_q <= 1'b0;
        if (mismatch) begin
          bad_q <= 1'b1;
        end
      end
      if (restart) begin
        // wrong path is dropped, including any stall on it
        bad_q    <= 1'b0;
        hazard_q <= 1'b0;
        cond_q   <= 1'b0;
        pc_q     <= restart_pc_q;
      end else if (resume) begin
        hazard_q <= 1'b0;
        pc_q     <= commit_i.redirect ? commit_i.npc : pc_plus4;
      end else if (accept) begin
        if (predict) begin
          pc_q   <= btb_q;
          spec_q <= 1'b1;
          cond_q <= is_cond;
        end else if (is_ctrl || is_load || is_fence) begin
          hazard_q <= 1'b1;
        end else begin
          pc_q <= pc_plus4;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (commit_i.redirect) begin
      btb_q <= commit_i.npc;
    end
    if (predict) begin
      guess_pc_q     <= pc_q;
      guess_target_q <= btb_q;
      fall_through_q <= pc_plus4;
    end
    // not-taken branch falls through, everything else follows npc
    if (mismatch) begin
      restart_pc_q <= (cond_q && commit_i.retire) ? fall_through_q : commit_i.npc;
    end
  end

endmodule

// File: l1i_cache.sv
module l1i_cache (
  input  logic                 clk,
  input  logic                 rst,
  input  fetch_pkg::addr_t     addr_i,
  input  logic                 invalidate_i,
  input  fetch_pkg::word_rsp_t mem_rsp_i,
  output logic                 hit_o,
  output rv_isa_pkg::inst_t    inst_o,
  output logic                 idle_o,
  output fetch_pkg::word_req_t mem_req_o
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_EVEN,
    ST_GAP,
    ST_ODD,
    ST_SETTLE
  } state_e;

  state_e                                state_q;
  logic [fetch_pkg::L1I_SETS-1:0]        valid_q;
  rv_isa_pkg::inst_t                     data_q [fetch_pkg::L1I_SETS][fetch_pkg::L1I_LINE_WORDS];
  logic [fetch_pkg::TAG_W-1:0]           tag_q [fetch_pkg::L1I_SETS][fetch_pkg::L1I_LINE_WORDS];
  logic [fetch_pkg::L1I_LINE_ADDR_W-1:0] fill_line_q;

  logic [fetch_pkg::TAG_W-1:0]         addr_tag;
  logic [fetch_pkg::L1I_SETS_LOG2-1:0] addr_idx;
  logic [fetch_pkg::L1I_LINE_LOG2-1:0] addr_off;
  logic [fetch_pkg::TAG_W-1:0]         fill_tag;
  logic [fetch_pkg::L1I_SETS_LOG2-1:0] fill_idx;
  logic [fetch_pkg::L1I_LINE_LOG2-1:0] fill_off;
  logic                                lookup_state;
  logic                                miss;
  logic                                fill_write;

  assign addr_tag = addr_i[31:fetch_pkg::TAG_LSB];
  assign addr_idx = addr_i[fetch_pkg::TAG_LSB-1:fetch_pkg::IDX_LSB];
  assign addr_off = addr_i[fetch_pkg::IDX_LSB-1:fetch_pkg::OFF_LSB];

  assign fill_tag = fill_line_q[fetch_pkg::L1I_LINE_ADDR_W-1:fetch_pkg::L1I_SETS_LOG2];
  assign fill_idx = fill_line_q[fetch_pkg::L1I_SETS_LOG2-1:0];
  // even word first, then the odd one
  assign fill_off = {fetch_pkg::L1I_LINE_LOG2{state_q == ST_ODD}};

  // lookups only when no fill is writing the arrays
  assign lookup_state = (state_q == ST_IDLE) || (state_q == ST_SETTLE);
  assign hit_o        = lookup_state && valid_q[addr_idx] &&
                        (tag_q[addr_idx][addr_off] == addr_tag);
  assign inst_o       = data_q[addr_idx][addr_off];
  assign idle_o       = state_q == ST_IDLE;

  assign miss       = (state_q == ST_IDLE) && !hit_o;
  assign fill_write = ((state_q == ST_EVEN) || (state_q == ST_ODD)) && mem_rsp_i.valid;

  always_comb begin
    mem_req_o.valid = miss || (state_q == ST_EVEN) || (state_q == ST_ODD);
    if (state_q == ST_IDLE) begin
      mem_req_o.addr = {addr_i[31:fetch_pkg::IDX_LSB], {fetch_pkg::IDX_LSB{1'b0}}};
    end else begin
      mem_req_o.addr = {fill_line_q, fill_off, {fetch_pkg::L1I_BYTE_LOG2{1'b0}}};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= ST_IDLE;
      valid_q <= '0;
    end else begin
      case (state_q)
        ST_IDLE: begin
          if (invalidate_i) begin
            valid_q <= '0;
          end
          if (miss) begin
            state_q <= ST_EVEN;
          end
        end
        ST_EVEN: begin
          if (mem_rsp_i.valid) begin
            state_q <= ST_GAP;
          end
        end
        ST_GAP: begin
          state_q <= ST_ODD;
        end
        ST_ODD: begin
          if (mem_rsp_i.valid) begin
            state_q           <= ST_SETTLE;
            valid_q[fill_idx] <= 1'b1;
          end
        end
        ST_SETTLE: begin
          // a fence.i can also be taken on the settle hit
          if (invalidate_i) begin
            valid_q <= '0;
          end
          state_q <= ST_IDLE;
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (miss) begin
      fill_line_q <= addr_i[31:fetch_pkg::IDX_LSB];
    end
    if (fill_write) begin
      data_q[fill_idx][fill_off] <= mem_rsp_i.data;
      tag_q[fill_idx][fill_off]  <= fill_tag;
    end
  end

endmodule

// File: apb_fetch_master.sv
module apb_fetch_master (
  input  logic                 clk,
  input  logic                 rst,
  input  fetch_pkg::word_req_t req_i,
  input  fetch_pkg::apb_rsp_t  apb_rsp_i,
  output fetch_pkg::word_rsp_t rsp_o,
  output fetch_pkg::apb_req_t  apb_req_o
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS
  } state_e;

  state_e           state_q;
  fetch_pkg::addr_t addr_q;
  logic [31:0]      data_q;
  logic             rsp_valid_q;
  logic             start;
  logic             done;

  // requester still holds valid while its response pulses
  assign start = (state_q == ST_IDLE) && req_i.valid && !rsp_valid_q;
  assign done  = (state_q == ST_ACCESS) && apb_rsp_i.pready;

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q     <= ST_IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      rsp_valid_q <= done;
      case (state_q)
        ST_IDLE: begin
          if (start) begin
            state_q <= ST_SETUP;
          end
        end
        ST_SETUP: begin
          state_q <= ST_ACCESS;
        end
        ST_ACCESS: begin
          if (apb_rsp_i.pready) begin
            state_q <= ST_IDLE;
          end
        end
        default: begin
          state_q <= ST_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      addr_q <= req_i.addr;
    end
    if (done) begin
      data_q <= apb_rsp_i.prdata;
    end
  end

  always_comb begin
    apb_req_o.psel    = state_q != ST_IDLE;
    apb_req_o.penable = state_q == ST_ACCESS;
    apb_req_o.paddr   = addr_q;
    rsp_o.valid       = rsp_valid_q;
    rsp_o.data        = data_q;
  end

endmodule

// File: fetch_top.sv
module fetch_top (
  input  logic                    clk,
  input  logic                    rst,
  input  fetch_pkg::commit_t      commit_i,
  input  logic                    fetch_ready_i,
  input  fetch_pkg::apb_rsp_t     apb_rsp_i,
  output logic                    fetch_valid_o,
  output fetch_pkg::fetch_out_t   fetch_o,
  output fetch_pkg::spec_status_t spec_o,
  output fetch_pkg::apb_req_t     apb_req_o
);

  fetch_pkg::addr_t     lookup_addr;
  logic                 invalidate;
  logic                 hit;
  rv_isa_pkg::inst_t    inst;
  logic                 cache_idle;
  fetch_pkg::word_req_t word_req;
  fetch_pkg::word_rsp_t word_rsp;

  fetch_ctrl u_ctrl (
    .clk          (clk),
    .rst          (rst),
    .commit_i     (commit_i),
    .hit_i        (hit),
    .inst_i       (inst),
    .cache_idle_i (cache_idle),
    .fetch_ready_i(fetch_ready_i),
    .lookup_addr_o(lookup_addr),
    .invalidate_o (invalidate),
    .fetch_valid_o(fetch_valid_o),
    .fetch_o      (fetch_o),
    .spec_o       (spec_o)
  );

  l1i_cache u_l1i (
    .clk         (clk),
    .rst         (rst),
    .addr_i      (lookup_addr),
    .invalidate_i(invalidate),
    .mem_rsp_i   (word_rsp),
    .hit_o       (hit),
    .inst_o      (inst),
    .idle_o      (cache_idle),
    .mem_req_o   (word_req)
  );

  apb_fetch_master u_apb (
    .clk      (clk),
    .rst      (rst),
    .req_i    (word_req),
    .apb_rsp_i(apb_rsp_i),
    .rsp_o    (word_rsp),
    .apb_req_o(apb_req_o)
  );

endmodule

// File: fetch_top_sva.sv
module fetch_top_sva (
  input logic                clk,
  input logic                rst,
  input fetch_pkg::apb_req_t apb_req_o,
  input fetch_pkg::apb_rsp_t apb_rsp_i
);

  // access phase must come straight from setup
  penable_after_setup: assert property (@(posedge clk) disable iff (rst)
    $rose(apb_req_o.penable) |-> $past(apb_req_o.psel && !apb_req_o.penable))
    else $error("penable rose without a setup cycle");

  paddr_stable: assert property (@(posedge clk) disable iff (rst)
    (apb_req_o.psel && $past(apb_req_o.psel)) |-> $stable(apb_req_o.paddr))
    else $error("paddr changed during a transfer");

  // psel only drops once the slave has answered
  psel_held: assert property (@(posedge clk) disable iff (rst)
    $fell(apb_req_o.psel) |-> $past(apb_req_o.penable && apb_rsp_i.pready))
    else $error("psel dropped before pready");

endmodule

bind apb_fetch_master fetch_top_sva u_sva (
  .clk      (clk),
  .rst      (rst),
  .apb_req_o(apb_req_o),
  .apb_rsp_i(apb_rsp_i)
);

// File: fetch_top_tb.sv
module fetch_top_tb;

  localparam int NUM_TESTS = 6;
  localparam int MAX_LEN   = 7;

  logic                    clk;
  logic                    rst;
  fetch_pkg::commit_t      commit;
  logic                    fetch_ready;
  fetch_pkg::apb_rsp_t     apb_rsp = '0;
  logic                    fetch_valid;
  fetch_pkg::fetch_out_t   fetch_out;
  fetch_pkg::spec_status_t spec;
  fetch_pkg::apb_req_t     apb_req;

  // test table
  string            test_name  [NUM_TESTS];
  bit               rand_ready [NUM_TESTS];
  fetch_pkg::addr_t ovr_addr   [NUM_TESTS][$];
  logic [31:0]      ovr_word   [NUM_TESTS][$];
  fetch_pkg::addr_t scr_pc     [NUM_TESTS][$];
  bit               scr_redir  [NUM_TESTS][$];
  fetch_pkg::addr_t scr_npc    [NUM_TESTS][$];
  bit               scr_stall  [NUM_TESTS][$];
  fetch_pkg::addr_t exp_pc     [NUM_TESTS][$];
  int               exp_good   [NUM_TESTS];
  int               exp_bad    [NUM_TESTS];
  bit               exp_active [NUM_TESTS];
  int               exp_xfer   [NUM_TESTS];

  logic [31:0] mem_ovr [fetch_pkg::addr_t];
  int          xfers;
  int          waits;
  int          cycles = 0;
  int          limit = 1000000;
  int          errors;
  int          failed_tests = 0;

  fetch_top u_dut (
    .clk          (clk),
    .rst          (rst),
    .commit_i     (commit),
    .fetch_ready_i(fetch_ready),
    .apb_rsp_i    (apb_rsp),
    .fetch_valid_o(fetch_valid),
    .fetch_o      (fetch_out),
    .spec_o       (spec),
    .apb_req_o    (apb_req)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // background words are plain addi, never control or memory ops
  function automatic logic [31:0] pattern_word(fetch_pkg::addr_t a);
    return {a[13:2] ^ a[31:20], a[18:14], 3'b000, 5'd1, 7'h13};
  endfunction

  function automatic logic [31:0] read_word(fetch_pkg::addr_t a);
    if (mem_ovr.exists(a)) begin
      return mem_ovr[a];
    end
    return pattern_word(a);
  endfunction

  // apb memory with 0 to 2 wait states
  always @(posedge clk) begin
    #1;
    apb_rsp.pslverr = 1'b0;
    if (rst) begin
      xfers          = 0;
      apb_rsp.pready = 1'b0;
    end else if (apb_req.psel && !apb_req.penable) begin
      waits          = int'($urandom % 3);
      apb_rsp.pready = 1'b0;
    end else if (apb_req.psel && apb_req.penable && waits == 0) begin
      apb_rsp.pready = 1'b1;
      apb_rsp.prdata = read_word(apb_req.paddr);
      xfers          = xfers + 1;
    end else begin
      if (apb_req.psel) begin
        waits = waits - 1;
      end
      apb_rsp.pready = 1'b0;
    end
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= limit) begin
      $display("timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_fetch(string name, fetch_pkg::fetch_out_t exp,
                             fetch_pkg::fetch_out_t act);
    if (act !== exp) begin
      $display("FAIL %s fetch: expected pc=%h inst=%h, actual pc=%h inst=%h",
               name, exp.pc, exp.inst, act.pc, act.inst);
      errors = errors + 1;
    end
  endtask

  task automatic check_spec(string name, fetch_pkg::spec_status_t exp,
                            fetch_pkg::spec_status_t act);
    if (act !== exp) begin
      $display("FAIL %s spec seen: expected %b, actual %b", name, exp, act);
      errors = errors + 1;
    end
  endtask

  task automatic check_count(string name, string what, int exp, int act);
    if (act != exp) begin
      $display("FAIL %s %s: expected %0d, actual %0d", name, what, exp, act);
      errors = errors + 1;
    end
  endtask

  // nothing may be offered while a stalled instruction waits for its commit
  task automatic check_stalled(string name, logic valid, fetch_pkg::addr_t pc);
    if (valid !== 1'b0) begin
      $display("FAIL %s stall: expected fetch_valid=0, actual %b at pc=%h",
               name, valid, pc);
      errors = errors + 1;
    end
  endtask

  task automatic build_table();
    logic [31:0] jal;
    logic [31:0] lw;
    jal = {25'd0, rv_isa_pkg::OP_JAL};
    lw  = {25'd0, rv_isa_pkg::OP_LOAD};
    test_name = '{"seq_fetch", "refetch_hits", "stall_commit",
                  "predict_good", "predict_bad", "fence_refill"};
    rand_ready = '{1'b1, 1'b1, 1'b1, 1'b0, 1'b0, 1'b0};
    exp_good   = '{0, 0, 0, 1, 0, 0};
    exp_bad    = '{0, 0, 0, 0, 1, 0};
    exp_active = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b1, 1'b0};
    exp_xfer   = '{8, 4, 6, 6, 6, 4};
    exp_pc[0] = '{32'h1000, 32'h1004, 32'h1008, 32'h100c,
                  32'h1010, 32'h1014, 32'h1018};
    ovr_addr[1] = '{32'h100c};
    ovr_word[1] = '{jal};
    scr_pc[1] = '{32'h100c};
    scr_redir[1] = '{1'b1};
    scr_npc[1] = '{32'h1000};
    scr_stall[1] = '{1'b1};
    exp_pc[1] = '{32'h1000, 32'h1004, 32'h1008, 32'h100c,
                  32'h1000, 32'h1004, 32'h1008};
    // load is followed by a hit, retires carry no target
    ovr_addr[2] = '{32'h1000, 32'h1008};
    ovr_word[2] = '{lw, jal};
    scr_pc[2] = '{32'h1000, 32'h1008};
    scr_redir[2] = '{1'b0, 1'b1};
    scr_npc[2] = '{32'h0000_0000, 32'h1020};
    scr_stall[2] = '{1'b1, 1'b1};
    exp_pc[2] = '{32'h1000, 32'h1004, 32'h1008, 32'h1020, 32'h1024};
    // loop back to the trained target
    ovr_addr[3] = '{32'h1000, 32'h1020};
    ovr_word[3] = '{jal, jal};
    scr_pc[3] = '{32'h1000, 32'h1020};
    scr_redir[3] = '{1'b1, 1'b1};
    scr_npc[3] = '{32'h1018, 32'h1018};
    scr_stall[3] = '{1'b1, 1'b0};
    exp_pc[3] = '{32'h1000, 32'h1018, 32'h101c, 32'h1020,
                  32'h1018, 32'h101c, 32'h1020};
    // branch guessed taken, then retired as not taken
    ovr_addr[4] = '{32'h1000, 32'h1014};
    ovr_word[4] = '{jal, {25'd0, rv_isa_pkg::OP_BRANCH}};
    scr_pc[4] = '{32'h1000, 32'h1014};
    scr_redir[4] = '{1'b1, 1'b0};
    scr_npc[4] = '{32'h1010, 32'h0000_0000};
    scr_stall[4] = '{1'b1, 1'b0};
    exp_pc[4] = '{32'h1000, 32'h1010, 32'h1014, 32'h1018, 32'h101c};
    ovr_addr[5] = '{32'h1004};
    ovr_word[5] = '{rv_isa_pkg::INST_FENCE_I};
    scr_pc[5] = '{32'h1004};
    scr_redir[5] = '{1'b1};
    scr_npc[5] = '{32'h1000};
    scr_stall[5] = '{1'b1};
    exp_pc[5] = '{32'h1000, 32'h1004, 32'h1000};
  endtask

  task automatic run_test(int t);
    fetch_pkg::fetch_out_t   exp;
    fetch_pkg::spec_status_t seen;
    fetch_pkg::spec_status_t exp_seen;
    int n;
    int sidx;
    int good_cnt;
    int bad_cnt;
    int xfer_snap;
    bit bad_prev;
    bit pend;
    bit hold;
    errors = 0;
    mem_ovr.delete();
    for (int i = 0; i < ovr_addr[t].size(); i++) begin
      mem_ovr[ovr_addr[t][i]] = ovr_word[t][i];
    end
    rst = 1'b1;
    commit = '0;
    fetch_ready = 1'b0;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;
    n = 0;
    sidx = 0;
    good_cnt = 0;
    bad_cnt = 0;
    xfer_snap = 0;
    bad_prev = 1'b0;
    pend = 1'b0;
    hold = 1'b0;
    seen = '0;
    while (n < exp_pc[t].size()) begin
      @(posedge clk);
      if (hold) begin
        check_stalled(test_name[t], fetch_valid, fetch_out.pc);
      end
      hold = 1'b0;
      seen = seen | spec;
      if (spec.good) good_cnt++;
      if (spec.bad && !bad_prev) bad_cnt++;
      bad_prev = spec.bad;
      if (fetch_valid && fetch_ready) begin
        exp.pc   = exp_pc[t][n];
        exp.inst = read_word(exp_pc[t][n]);
        check_fetch(test_name[t], exp, fetch_out);
        n++;
        if (sidx < scr_pc[t].size() && fetch_out.pc == scr_pc[t][sidx]) begin
          pend = 1'b1;
        end
        if (n == exp_pc[t].size()) begin
          xfer_snap = xfers;
        end
      end
      #1;
      commit = '0;
      if (pend) begin
        // back end commits one cycle after the transfer
        commit.redirect = scr_redir[t][sidx];
        commit.retire   = !scr_redir[t][sidx];
        commit.pc       = scr_pc[t][sidx];
        commit.npc      = scr_npc[t][sidx];
        hold            = scr_stall[t][sidx];
        sidx++;
        pend = 1'b0;
      end
      fetch_ready = rand_ready[t] ? (($urandom % 4) != 0) : 1'b1;
    end
    exp_seen.active = exp_active[t];
    exp_seen.good   = exp_good[t] != 0;
    exp_seen.bad    = exp_bad[t] != 0;
    check_spec(test_name[t], exp_seen, seen);
    check_count(test_name[t], "good pulses", exp_good[t], good_cnt);
    check_count(test_name[t], "bad events", exp_bad[t], bad_cnt);
    check_count(test_name[t], "apb transfers", exp_xfer[t], xfer_snap);
    if (errors == 0) begin
      $display("PASS %s", test_name[t]);
    end else begin
      $display("%s finished with %0d mismatches", test_name[t], errors);
      failed_tests++;
    end
  endtask

  initial begin
    void'($urandom(32'h27c9ddb9));
    rst = 1'b1;
    commit = '0;
    fetch_ready = 1'b0;
    build_table();
    limit = 64 * MAX_LEN * NUM_TESTS;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("tests run: %0d, passed: %0d, failed: %0d",
             NUM_TESTS, NUM_TESTS - failed_tests, failed_tests);
    if (failed_tests == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: fetch_top.f
rv_isa_pkg.sv
fetch_pkg.sv
fetch_ctrl.sv
l1i_cache.sv
apb_fetch_master.sv
fetch_top.sv
fetch_top_sva.sv
fetch_top_tb.sv

// File: run.sh
#!/bin/sh
set -e
verilator --binary --timing --assert -f fetch_top.f --top-module fetch_top_tb -o sim_fetch
out=$(./obj_dir/sim_fetch)
echo "$out"
if echo "$out" | grep -qx "Test passed"; then
  exit 0
else
  exit 1
fi
